// ==== filelist.f ====
rtl/rec_residual_pkg.sv
rtl/rec_intra_pkg.sv
rtl/iqit_clk_en.sv
rtl/intra_nbr_clk_en.sv
rtl/intra_seed_clk_en.sv
rtl/rec_clk_en_top.sv
test/tb_clk_gen.sv
test/tb_rec_clk_en.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, log in sim.log
rm -f sim.log
verilator --binary --timing -f filelist.f --top-module tb_rec_clk_en \
	&& ./obj_dir/Vtb_rec_clk_en > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
exit 0

// ==== test/tb_rec_clk_en.sv ====
// testbench for the reconstruction clock enable generator
// random status vectors from a fixed seed
// reference model of the enable rules, checks one cycle after each vector
// timeout counter and closing result line

`timescale 1ns/1ns

module tb_rec_clk_en;

	localparam int reset_cycles = 5;
	localparam int num_vectors  = 2000;
	// reset, one cycle per vector, then margin
	localparam int cycle_limit  = reset_cycles + num_vectors + 95;

	logic                           clk;
	logic                           reset;
	rec_residual_pkg::iqit_status_t iqit_status;
	rec_intra_pkg::intra_status_t   intra_status;
	rec_residual_pkg::iqit_en_t     iqit_en;
	rec_intra_pkg::intra_en_t       intra_en;
	rec_residual_pkg::iqit_en_t     exp_iqit;
	rec_intra_pkg::intra_en_t       exp_intra;
	integer                         seed;
	int                             cycles;
	int                             check_count;
	int                             error_count;

	tb_clk_gen clk_gen (.clk(clk));

	rec_clk_en_top uut (
		.clk          (clk),
		.reset        (reset),
		.iqit_status  (iqit_status),
		.intra_status (intra_status),
		.iqit_en      (iqit_en),
		.intra_en     (intra_en)
	);

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	function automatic rec_residual_pkg::iqit_en_t model_iqit(
		input rec_residual_pkg::iqit_status_t s);
		logic valid_end;
		logic dc;
		logic cdc;
		logic ac;
		rec_residual_pkg::iqit_en_t e;
		valid_end = s.end_of_nonzero_coeff &&
			(s.cavlc_state != rec_residual_pkg::cavlc_num_coeff_lut);
		dc = 1'b0;
		cdc = 1'b0;
		ac = 1'b0;
		case (s.residual_state)
			rec_residual_pkg::intra16x16_dc_level_s: dc = 1'b1;
			rec_residual_pkg::chroma_dc_level_cb_s,
			rec_residual_pkg::chroma_dc_level_cr_s: begin
				dc = 1'b1;
				cdc = 1'b1;
			end
			rec_residual_pkg::intra16x16_ac_level_s, rec_residual_pkg::luma_level_s,
			rec_residual_pkg::chroma_ac_level_cb_s,
			rec_residual_pkg::chroma_ac_level_cr_s: ac = 1'b1;
			default: ;
		endcase
		e.oned = (valid_end && dc) || (ac && s.rescale_counter == 3'd4) ||
			(s.oned_counter != 3'd0);
		e.twod = (s.oned_counter == 3'd1 && !cdc) || (s.twod_counter != 3'd0);
		// luma dc is a dc state that is not chroma
		e.rescale = (valid_end && ac) || (dc && !cdc && s.twod_counter == 3'd4) ||
			(cdc && s.oned_counter == 3'd1) || (s.rescale_counter != 3'd0);
		e.rounding = (ac && s.twod_counter == 3'd4) || (s.rounding_counter != 3'd0);
		return e;
	endfunction

	function automatic rec_intra_pkg::intra_en_t model_intra(
		input rec_intra_pkg::intra_status_t s);
		logic i4;
		logic lastc;
		logic summed;
		logic luma;
		logic [4:0] blk;
		rec_intra_pkg::intra_en_t e;
		i4 = s.mb_type_general[3:2] == 2'b11;
		lastc = s.mb_num_h == 4'd10;
		summed = s.sum_counter == 3'd3;
		blk = s.rec_counter;
		luma = blk < 5'd16;
		if (i4)
			e.a_luma = summed && luma && !(lastc && blk inside {5'd5, 5'd7, 5'd13, 5'd15});
		else
			e.a_luma = summed && luma && !lastc && !s.next_mb_is_skip &&
				blk inside {5'd5, 5'd7, 5'd13, 5'd15};
		e.a_cb = summed && !lastc && blk inside {5'd17, 5'd19} && (i4 || !s.next_mb_is_skip);
		e.a_cr = summed && !lastc && blk inside {5'd21, 5'd23} && (i4 || !s.next_mb_is_skip);
		e.b = (i4 && luma && (s.preload_counter == 3'd1 || s.sum_counter < 3'd4)) ||
			(s.mb_type_general[3:2] == 2'b10 && luma && s.preload_counter != 3'd0) ||
			(s.mb_type_general[3] && !luma && s.preload_counter != 3'd0);
		e.c_luma = i4 && s.preload_counter == 3'd2 &&
			(s.intra4x4_mode == rec_intra_pkg::intra4x4_diagonal_down_left ||
			s.intra4x4_mode == rec_intra_pkg::intra4x4_vertical_left);
		e.d = (s.sum_counter == 3'd1 && !lastc && s.mb_num_v != 4'd0 &&
			!s.next_mb_is_skip && blk inside {5'd15, 5'd19, 5'd23}) ||
			(i4 && s.preload_counter == 3'd2 && s.intra4x4_mode inside {
			rec_intra_pkg::intra4x4_diagonal_down_right,
			rec_intra_pkg::intra4x4_vertical_right,
			rec_intra_pkg::intra4x4_horizontal_down}) ||
			(i4 && summed && blk inside {5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd6, 5'd8, 5'd9, 5'd12});
		e.seed = (s.precompute_counter == 4'd1) || (s.intra16x16_mode == 2'd3 &&
			((s.calculate_counter == 3'd4 && blk inside {5'd0, 5'd2, 5'd8}) ||
			(s.calculate_counter == 3'd1 && blk inside {5'd1, 5'd3, 5'd9, 5'd11}))) ||
			(s.chroma_mode == 2'd3 && s.calculate_counter == 3'd4 && blk inside {5'd16, 5'd20});
		return e;
	endfunction

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	// mostly idle counter, sometimes 1 to 4
	function automatic logic [2:0] small_cnt();
		if ({$random(seed)} % 4 != 0)
			return 3'd0;
		return 3'(1 + {$random(seed)} % 4);
	endfunction

	// status that would raise the enables if reset were low
	task drive_busy(input logic [4:0] blk);
		iqit_status.end_of_nonzero_coeff = 1'b1;
		iqit_status.cavlc_state = 4'd0;
		iqit_status.residual_state = rec_residual_pkg::luma_level_s;
		iqit_status.oned_counter = 3'd2;
		iqit_status.twod_counter = 3'd2;
		iqit_status.rescale_counter = 3'd2;
		iqit_status.rounding_counter = 3'd2;
		intra_status = '0;
		intra_status.mb_num_h = 4'd1;
		intra_status.mb_num_v = 4'd1;
		intra_status.mb_type_general = 4'b1100;
		intra_status.rec_counter = blk;
		intra_status.sum_counter = 3'd3;
		intra_status.preload_counter = 3'd2;
		intra_status.precompute_counter = 4'd1;
		intra_status.intra4x4_mode = rec_intra_pkg::intra4x4_diagonal_down_left;
	endtask

	task draw_vector();
		logic [3:0] r;
		int         k;
		// codes 8 to 11 are unused, map onto chroma ac
		r = 4'({$random(seed)} % 10);
		if (r >= 4'd8)
			r = r + 4'd4;
		iqit_status.end_of_nonzero_coeff = 1'($random(seed));
		iqit_status.cavlc_state = ({$random(seed)} % 2 == 0) ?
			rec_residual_pkg::cavlc_num_coeff_lut : 4'($random(seed));
		iqit_status.residual_state = rec_residual_pkg::residual_state_t'(r);
		iqit_status.oned_counter = small_cnt();
		iqit_status.twod_counter = small_cnt();
		iqit_status.rescale_counter = small_cnt();
		iqit_status.rounding_counter = small_cnt();
		// last column about one time in four
		intra_status.mb_num_h = ({$random(seed)} % 4 == 0) ? 4'd10 : 4'($random(seed));
		intra_status.mb_num_v = ({$random(seed)} % 4 == 0) ? 4'd0 : 4'($random(seed));
		intra_status.next_mb_is_skip = 1'($random(seed));
		// intra4x4, intra16x16 or inter class
		intra_status.mb_type_general = 4'($random(seed));
		k = {$random(seed)} % 3;
		if (k == 0)
			intra_status.mb_type_general[3:2] = 2'b11;
		else if (k == 1)
			intra_status.mb_type_general[3:2] = 2'b10;
		else
			intra_status.mb_type_general[3] = 1'b0;
		intra_status.rec_counter = 5'({$random(seed)} % 24);
		intra_status.sum_counter = ({$random(seed)} % 4 == 0) ?
			3'($random(seed)) : 3'({$random(seed)} % 5);
		intra_status.preload_counter = small_cnt();
		intra_status.precompute_counter = {1'b0, small_cnt()};
		intra_status.calculate_counter = small_cnt();
		intra_status.intra4x4_mode = rec_intra_pkg::intra4x4_mode_t'(4'({$random(seed)} % 9));
		intra_status.intra16x16_mode = 2'($random(seed));
		intra_status.chroma_mode = 2'($random(seed));
	endtask

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	task check_bit(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Error: %s expected %h got %h at cycle %0d", name, exp, act, cycles);
		end
	endtask

	task compare_all(input rec_residual_pkg::iqit_en_t ei, input rec_intra_pkg::intra_en_t ni);
		check_bit("iqit_en.oned", ei.oned, iqit_en.oned);
		check_bit("iqit_en.twod", ei.twod, iqit_en.twod);
		check_bit("iqit_en.rescale", ei.rescale, iqit_en.rescale);
		check_bit("iqit_en.rounding", ei.rounding, iqit_en.rounding);
		check_bit("intra_en.a_luma", ni.a_luma, intra_en.a_luma);
		check_bit("intra_en.a_cb", ni.a_cb, intra_en.a_cb);
		check_bit("intra_en.a_cr", ni.a_cr, intra_en.a_cr);
		check_bit("intra_en.b", ni.b, intra_en.b);
		check_bit("intra_en.c_luma", ni.c_luma, intra_en.c_luma);
		check_bit("intra_en.d", ni.d, intra_en.d);
		check_bit("intra_en.seed", ni.seed, intra_en.seed);
	endtask

	// run limit
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: no result after %0d cycles", cycle_limit);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		seed = 59;
		check_count = 0;
		error_count = 0;
		reset = 1'b1;
		iqit_status = '0;
		intra_status = '0;
		// all enables cleared under reset, even with a busy status
		for (int i = 0; i < reset_cycles; i++) begin
			drive_busy((i % 3 == 0) ? 5'd0 : ((i % 3 == 1) ? 5'd17 : 5'd21));
			@(posedge clk);
			#1;
			compare_all('0, '0);
		end
		reset = 1'b0;
		// new vector every cycle, enables checked one edge later
		for (int i = 0; i < num_vectors; i++) begin
			draw_vector();
			exp_iqit = model_iqit(iqit_status);
			exp_intra = model_intra(intra_status);
			@(posedge clk);
			#1;
			compare_all(exp_iqit, exp_intra);
		end
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== test/tb_clk_gen.sv ====
// testbench clock source
// free-running clock, 40 ns period

`timescale 1ns/1ns

module tb_clk_gen (
	output logic clk
);

	// half of the 40 ns period
	localparam int half_period = 20;

	initial clk = 1'b0;

	always #(half_period) clk = ~clk;

endmodule

// ==== rtl/rec_clk_en_top.sv ====
// reconstruction clock enable generator, top level
// iqit enables, intra neighbor enables and the seed enable

`timescale 1ns/1ns

module rec_clk_en_top (
	input  logic                           clk,
	input  logic                           reset,
	input  rec_residual_pkg::iqit_status_t iqit_status,
	input  rec_intra_pkg::intra_status_t   intra_status,
	output rec_residual_pkg::iqit_en_t     iqit_en,
	output rec_intra_pkg::intra_en_t       intra_en
);

	logic en_a_luma;
	logic en_a_cb;
	logic en_a_cr;
	logic en_b;
	logic en_c_luma;
	logic en_d;
	logic en_seed;

	iqit_clk_en u_iqit (
		.clk    (clk),
		.reset  (reset),
		.status (iqit_status),
		.en     (iqit_en)
	);

	intra_nbr_clk_en u_intra_nbr (
		.clk       (clk),
		.reset     (reset),
		.status    (intra_status),
		.en_a_luma (en_a_luma),
		.en_a_cb   (en_a_cb),
		.en_a_cr   (en_a_cr),
		.en_b      (en_b),
		.en_c_luma (en_c_luma),
		.en_d      (en_d)
	);

	intra_seed_clk_en u_intra_seed (
		.clk     (clk),
		.reset   (reset),
		.status  (intra_status),
		.en_seed (en_seed)
	);

	// neighbor and seed enables in one struct
	assign intra_en = '{a_luma: en_a_luma, a_cb: en_a_cb, a_cr: en_a_cr, b: en_b,
		c_luma: en_c_luma, d: en_d, seed: en_seed};

endmodule

// ==== rtl/intra_seed_clk_en.sv ====
// clock enable for the plane prediction seed register
// enable follows the status by one cycle

`timescale 1ns/1ns

module intra_seed_clk_en (
	input  logic                         clk,
	input  logic                         reset,
	input  rec_intra_pkg::intra_status_t status,
	output logic                         en_seed
);

	logic luma_plane;
	logic chroma_plane;
	logic next_seed;

	assign luma_plane   = status.intra16x16_mode == rec_intra_pkg::plane_mode;
	assign chroma_plane = status.chroma_mode == rec_intra_pkg::plane_mode;

	always_comb begin
		// first seed from precompute
		next_seed = status.precompute_counter == 4'd1;

		// 16x16 plane, seed steps across the luma blocks
		if (luma_plane) begin
			if (status.calculate_counter == 3'd4 &&
				status.rec_counter inside {5'd0, 5'd2, 5'd8}) begin
				next_seed = 1'b1;
			end
			if (status.calculate_counter == 3'd1 &&
				status.rec_counter inside {5'd1, 5'd3, 5'd9, 5'd11}) begin
				next_seed = 1'b1;
			end
		end

		// chroma plane, first block of cb and cr
		if (chroma_plane && status.calculate_counter == 3'd4 &&
			status.rec_counter inside {5'd16, 5'd20}) begin
			next_seed = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			en_seed <= 1'b0;
		end else begin
			en_seed <= next_seed;
		end
	end

endmodule

// ==== rtl/intra_nbr_clk_en.sv ====
// clock enables for the intra prediction neighbor registers
// left (a) luma, cb and cr, top (b), top-right (c) luma, top-left (d)
// enables follow the status by one cycle

`timescale 1ns/1ns

module intra_nbr_clk_en (
	input  logic                         clk,
	input  logic                         reset,
	input  rec_intra_pkg::intra_status_t status,
	output logic                         en_a_luma,
	output logic                         en_a_cb,
	output logic                         en_a_cr,
	output logic                         en_b,
	output logic                         en_c_luma,
	output logic                         en_d
);

	logic intra4x4;
	logic intra16x16;
	logic last_col;
	logic summed;
	logic luma_blk;
	logic right_most;
	logic next_a_luma;
	logic next_a_cb;
	logic next_a_cr;
	logic next_b;
	logic next_c_luma;
	logic next_d;

	// ----------------------------------------------------------------------
	// common decode
	// ----------------------------------------------------------------------
	assign intra4x4   = status.mb_type_general[3:2] == rec_intra_pkg::mb_class_intra4x4;
	assign intra16x16 = status.mb_type_general[3:2] == rec_intra_pkg::mb_class_intra16x16;
	assign last_col   = status.mb_num_h == rec_intra_pkg::last_mb_col;
	assign summed     = status.sum_counter == rec_intra_pkg::sum_cnt_done;
	assign luma_blk   = status.rec_counter < rec_intra_pkg::luma_blk_count;

	// luma blocks on the right edge of the mb
	assign right_most = status.rec_counter inside {5'd5, 5'd7, 5'd13, 5'd15};

	// ----------------------------------------------------------------------
	// next enables
	// ----------------------------------------------------------------------
	always_comb begin
		// intra4x4 needs every summed block as left neighbor,
		// other types only the right edge for the next mb
		next_a_luma = summed && luma_blk && (
			(intra4x4 && !(last_col && right_most)) ||
			(!intra4x4 && !last_col && right_most && !status.next_mb_is_skip));

		// chroma right edge, kept for the next mb
		next_a_cb = summed && !last_col &&
			status.rec_counter inside {5'd17, 5'd19} &&
			(intra4x4 || !status.next_mb_is_skip);
		next_a_cr = summed && !last_col &&
			status.rec_counter inside {5'd21, 5'd23} &&
			(intra4x4 || !status.next_mb_is_skip);

		// top row: preload from ram, or during sum for intra4x4
		next_b =
			(intra4x4 && luma_blk &&
				(status.preload_counter == 3'd1 || status.sum_counter < 3'd4)) ||
			(intra16x16 && luma_blk && status.preload_counter != '0) ||
			(status.mb_type_general[3] && !luma_blk && status.preload_counter != '0);

		// top-right only for modes that read it
		next_c_luma = intra4x4 && status.preload_counter == 3'd2 &&
			status.intra4x4_mode inside {
				rec_intra_pkg::intra4x4_diagonal_down_left,
				rec_intra_pkg::intra4x4_vertical_left};

		// top-left from ram at the last block of each plane
		next_d = status.sum_counter == 3'd1 && !last_col &&
			status.mb_num_v != '0 && !status.next_mb_is_skip &&
			status.rec_counter inside {5'd15, 5'd19, 5'd23};
		if (intra4x4) begin
			// preload for modes that use the corner
			if (status.preload_counter == 3'd2 &&
				status.intra4x4_mode inside {
					rec_intra_pkg::intra4x4_diagonal_down_right,
					rec_intra_pkg::intra4x4_vertical_right,
					rec_intra_pkg::intra4x4_horizontal_down}) begin
				next_d = 1'b1;
			end
			// inner blocks take the corner from the sum output
			if (summed && status.rec_counter inside
				{5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd6, 5'd8, 5'd9, 5'd12}) begin
				next_d = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			en_a_luma <= 1'b0;
			en_a_cb   <= 1'b0;
			en_a_cr   <= 1'b0;
			en_b      <= 1'b0;
			en_c_luma <= 1'b0;
			en_d      <= 1'b0;
		end else begin
			en_a_luma <= next_a_luma;
			en_a_cb   <= next_a_cb;
			en_a_cr   <= next_a_cr;
			en_b      <= next_b;
			en_c_luma <= next_c_luma;
			en_d      <= next_d;
		end
	end

endmodule

// ==== rtl/iqit_clk_en.sv ====
// clock enables for inverse quantization and inverse transform
// 1-d idct, 2-d idct, rescale and rounding units
// enables follow the status by one cycle

`timescale 1ns/1ns

module iqit_clk_en (
	input  logic                          clk,
	input  logic                          reset,
	input  rec_residual_pkg::iqit_status_t status,
	output rec_residual_pkg::iqit_en_t     en
);

	logic cavlc_end;
	logic luma_dc;
	logic chroma_dc;
	logic ac_state;
	rec_residual_pkg::iqit_en_t en_next;

	// ----------------------------------------------------------------------
	// state decode
	// ----------------------------------------------------------------------
	// block ended with nonzero coeffs, counting done
	assign cavlc_end = status.end_of_nonzero_coeff &&
		status.cavlc_state != rec_residual_pkg::cavlc_num_coeff_lut;

	assign luma_dc = status.residual_state == rec_residual_pkg::intra16x16_dc_level_s;

	assign chroma_dc = status.residual_state inside {
		rec_residual_pkg::chroma_dc_level_cb_s,
		rec_residual_pkg::chroma_dc_level_cr_s};

	// all four ac kinds share one path
	assign ac_state = status.residual_state inside {
		rec_residual_pkg::intra16x16_ac_level_s,
		rec_residual_pkg::luma_level_s,
		rec_residual_pkg::chroma_ac_level_cb_s,
		rec_residual_pkg::chroma_ac_level_cr_s};

	// ----------------------------------------------------------------------
	// next enables
	// ----------------------------------------------------------------------
	always_comb begin
		// dc goes straight to 1-d after cavlc, ac after rescale
		en_next.oned = (cavlc_end && (luma_dc || chroma_dc)) ||
			(ac_state && status.rescale_counter == rec_residual_pkg::iqit_cnt_last) ||
			status.oned_counter != '0;

		// chroma dc is 2x2, no second pass
		en_next.twod = (status.oned_counter == 3'd1 && !chroma_dc) ||
			status.twod_counter != '0;

		// ac rescales first, luma dc after 2-d, chroma dc after 1-d
		en_next.rescale = (cavlc_end && ac_state) ||
			(luma_dc && status.twod_counter == rec_residual_pkg::iqit_cnt_last) ||
			(chroma_dc && status.oned_counter == 3'd1) ||
			status.rescale_counter != '0;

		// rounding only closes an ac transform
		en_next.rounding =
			(ac_state && status.twod_counter == rec_residual_pkg::iqit_cnt_last) ||
			status.rounding_counter != '0;
	end

	// enable flop, one cycle after status
	always_ff @(posedge clk) begin
		if (reset) begin
			en <= '0;
		end else begin
			en <= en_next;
		end
	end

endmodule

// ==== rtl/rec_intra_pkg.sv ====
// intra prediction side of the reconstruction clock enables
// intra 4x4 mode codes and the plane mode
// macroblock class codes from the general mb type
// block index type and picture geometry
// intra status and enable structs

package rec_intra_pkg;

	// ----------------------------------------------------------------------
	// prediction modes
	// ----------------------------------------------------------------------
	typedef enum logic [3:0] {
		intra4x4_vertical            = 4'b0000,
		intra4x4_horizontal          = 4'b0001,
		intra4x4_dc                  = 4'b0010,
		intra4x4_diagonal_down_left  = 4'b0011,
		intra4x4_diagonal_down_right = 4'b0100,
		intra4x4_vertical_right      = 4'b0101,
		intra4x4_horizontal_down     = 4'b0110,
		intra4x4_vertical_left       = 4'b0111,
		intra4x4_horizontal_up       = 4'b1000
	} intra4x4_mode_t;

	// same code for 16x16 and chroma plane
	localparam logic [1:0] plane_mode = 2'b11;

	// ----------------------------------------------------------------------
	// macroblock type and geometry
	// ----------------------------------------------------------------------
	// top two bits of mb_type_general
	localparam logic [1:0] mb_class_intra4x4   = 2'b11;
	localparam logic [1:0] mb_class_intra16x16 = 2'b10;

	// right-most mb column of the picture
	localparam logic [3:0] last_mb_col = 4'd10;

	// 4x4 block index, 0..15 luma then 16..23 chroma
	typedef logic [4:0] blk_idx_t;

	// first chroma block
	localparam blk_idx_t luma_blk_count = 5'd16;

	// sum step where the block is written back
	localparam logic [2:0] sum_cnt_done = 3'd3;

	// status seen from the intra predictor
	typedef struct packed {
		logic [3:0]     mb_num_h;
		logic [3:0]     mb_num_v;
		logic           next_mb_is_skip;
		logic [3:0]     mb_type_general;
		blk_idx_t       rec_counter;
		logic [2:0]     sum_counter;
		logic [2:0]     preload_counter;
		logic [3:0]     precompute_counter;
		logic [2:0]     calculate_counter;
		intra4x4_mode_t intra4x4_mode;
		logic [1:0]     intra16x16_mode;
		logic [1:0]     chroma_mode;
	} intra_status_t;

	// neighbor register and seed enables
	typedef struct packed {
		logic a_luma;
		logic a_cb;
		logic a_cr;
		logic b;
		logic c_luma;
		logic d;
		logic seed;
	} intra_en_t;

endpackage

// ==== rtl/rec_residual_pkg.sv ====
// residual side of the reconstruction clock enables
// residual state codes and the cavlc counting state
// iqit counter type and last-step value
// iqit status and enable structs

package rec_residual_pkg;

	// ----------------------------------------------------------------------
	// residual decoding states
	// ----------------------------------------------------------------------
	typedef enum logic [3:0] {
		rst_residual            = 4'b0000,
		intra16x16_dc_level_s   = 4'b0001,
		intra16x16_ac_level_s   = 4'b0011,
		intra16x16_ac_level_0_s = 4'b0010,
		luma_level_s            = 4'b0110,
		luma_level_0_s          = 4'b0111,
		chroma_dc_level_cb_s    = 4'b0101,
		chroma_dc_level_cr_s    = 4'b0100,
		chroma_ac_level_cb_s    = 4'b1100,
		chroma_ac_level_cr_s    = 4'b1101
	} residual_state_t;

	// cavlc still counting coeffs, block end not final yet
	localparam logic [3:0] cavlc_num_coeff_lut = 4'b0010;

	// idct, rescale and rounding step counters
	typedef logic [2:0] iqit_cnt_t;

	// final step of one pass
	localparam iqit_cnt_t iqit_cnt_last = 3'd4;

	// status seen from the iqit datapath
	typedef struct packed {
		logic            end_of_nonzero_coeff;
		logic [3:0]      cavlc_state;
		residual_state_t residual_state;
		iqit_cnt_t       oned_counter;
		iqit_cnt_t       twod_counter;
		iqit_cnt_t       rescale_counter;
		iqit_cnt_t       rounding_counter;
	} iqit_status_t;

	// one enable per iqit unit
	typedef struct packed {
		logic oned;
		logic twod;
		logic rescale;
		logic rounding;
	} iqit_en_t;

endpackage
